// File: cga_core.f
+incdir+bench
common/cga_pkg.sv
common/cga_ctl_if.sv
hdl/cga_dcd.sv
alu/cga_alu.sv
wrf/cga_wrf.sv
intr/cga_intr.sv
hdl/cga_core.sv
bench/tb_cga_core.sv

// File: bench/tb_cga_model.svh
/*
  Reference model for the CGA slice testbench
  ALU result and flags, condition test, interrupt line mapping,
  interrupt priority and the stimulus LFSR
*/
`ifndef TB_CGA_MODEL_SVH
`define TB_CGA_MODEL_SVH

function automatic cga_pkg::word_t ref_alu(input cga_pkg::alu_fn_e fn, input cga_pkg::word_t a,
                                           input cga_pkg::word_t b, output cga_pkg::flags_t fl);
  logic [16:0] wide;
  wide = '0;
  fl = '0;
  case (fn)
    cga_pkg::fn_add: begin
      wide = {1'b0, a} + {1'b0, b};
      fl.ovf = (a[15] == b[15]) && (wide[15] != a[15]);
    end
    cga_pkg::fn_sub: begin
      wide = {1'b0, a} + {1'b0, ~b} + 17'd1;
      fl.ovf = (a[15] != b[15]) && (wide[15] != a[15]);  // Signed A minus B
    end
    cga_pkg::fn_inc_a: begin
      wide = {1'b0, a} + 17'd1;
      fl.ovf = (a == 16'h7fff);
    end
    cga_pkg::fn_and:    wide[15:0] = a & b;
    cga_pkg::fn_or:     wide[15:0] = a | b;
    cga_pkg::fn_xor:    wide[15:0] = a ^ b;
    cga_pkg::fn_pass_a: wide[15:0] = a;
    default:            wide[15:0] = b;
  endcase
  fl.cry = wide[16];  // Only the adder forms reach bit 16
  fl.zf  = (wide[15:0] == 16'h0000);
  return wide[15:0];
endfunction

function automatic logic ref_cond(input cga_pkg::cond_e cond, input cga_pkg::flags_t fl);
  case (cond)
    cga_pkg::cond_zf:  return fl.zf;
    cga_pkg::cond_cry: return fl.cry;
    cga_pkg::cond_nzf: return !fl.zf;
    default:           return 1'b1;
  endcase
endfunction

// Lines 0 to 4 stand for levels 10, 11, 12, 13 and 15
function automatic cga_pkg::word_t line_pending(input logic [4:0] bint);
  cga_pkg::word_t m;
  m = '0;
  m[10] = !bint[0];
  m[11] = !bint[1];
  m[12] = !bint[2];
  m[13] = !bint[3];
  m[15] = !bint[4];
  return m;
endfunction

// Returns intrq_n and hands the winning level back through lvl
function automatic logic ref_priority(input cga_pkg::word_t pid, input cga_pkg::word_t pie,
                                      input cga_pkg::level_t pil, output cga_pkg::level_t lvl);
  logic found;
  found = 1'b0;
  lvl = '0;
  for (int i = 15; i >= 0; i--) begin
    if (pid[i] && pie[i] && !found) begin
      lvl = i[3:0];
      found = 1'b1;
    end
  end
  return !(found && (lvl > pil));
endfunction

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
endfunction

`endif

// File: bench/tb_cga_core.sv
/*
  Testbench for the CGA slice
  Drives microinstructions into the core, steps a reference model
  alongside it and compares bus, flags and interrupt outputs
*/
`timescale 1ns/1ps

module tb_cga_core;

  localparam int reset_cycles = 5;
  localparam int test_cycles  = 4 + 40 + 440 + 70 + 60;  // reset, wrf, alu, cond, intr
  localparam int timeout_cycles = 2 * test_cycles + reset_cycles;

  typedef struct packed {
    logic [31:0]     due;    // Cycle count when the outputs are compared
    cga_pkg::word_t  fidb;
    logic            oe;
    cga_pkg::flags_t fl;
    cga_pkg::level_t pil;
    cga_pkg::level_t lvl;
    logic            rq_n;
  } exp_t;

  logic mclk, reset, fidb_oe, zf, cry, ovf, intrq_n;
  cga_pkg::reg_addr_t cs_ra, cs_rb;
  cga_pkg::alu_fn_e cs_aluf;
  cga_pkg::bsrc_e cs_bsrc;
  cga_pkg::cond_e cs_cond;
  cga_pkg::comm_e cs_comm;
  cga_pkg::word_t cd, fidb_in, fidb_out;
  logic [4:0] bint_n;
  cga_pkg::level_t pil, int_level;

  // Reference model state
  cga_pkg::word_t m_regs [16];
  cga_pkg::word_t m_fidb, m_pid, m_pie;
  logic m_oe;
  cga_pkg::flags_t m_flags;
  cga_pkg::level_t m_pil;

  exp_t exp_q [$];
  int cyc = 0;
  int errs, checks, total_errs, n_tests, n_failed;
  string cur_test;
  logic [15:0] lfsr_state;

  `include "tb_cga_model.svh"

  cga_core uut (.*);

  initial begin
    mclk = 1'b0;
    forever #2 mclk = ~mclk;
  end

  always @(posedge mclk) cyc <= cyc + 1;

  initial begin
    wait (cyc >= timeout_cycles);
    $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check_word(input cga_pkg::word_t exp_w, act_w, input logic exp_oe, act_oe);
    checks++;
    if ({exp_oe, exp_w} !== {act_oe, act_w}) begin
      errs++;
      $display("Error %s: fidb_oe/fidb_out expected %b/%h actual %b/%h",
               cur_test, exp_oe, exp_w, act_oe, act_w);
    end
  endtask

  task automatic check_flags(input cga_pkg::flags_t exp_f, act_f);
    checks++;
    if (exp_f !== act_f) begin
      errs++;
      $display("Error %s: zf/cry/ovf expected %b actual %b", cur_test, exp_f, act_f);
    end
  endtask

  task automatic check_level(input cga_pkg::level_t exp_pil, act_pil, exp_lvl, act_lvl,
                             input logic exp_rq, act_rq);
    checks++;
    if ({exp_pil, exp_lvl, exp_rq} !== {act_pil, act_lvl, act_rq}) begin
      errs++;
      $display("Error %s: pil/int_level/intrq_n expected %0d/%0d/%b actual %0d/%0d/%b",
               cur_test, exp_pil, exp_lvl, exp_rq, act_pil, act_lvl, act_rq);
    end
  endtask

  // Compare one cycle after each microinstruction is sampled
  always @(negedge mclk) begin : compare
    exp_t e;
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
      check_word(e.fidb, fidb_out, e.oe, fidb_oe);
      check_flags(e.fl, {zf, cry, ovf});
      check_level(e.pil, pil, e.lvl, int_level, e.rq_n, intrq_n);
    end
  end

  // Drive one microinstruction and step the model through it
  task automatic apply(input cga_pkg::reg_addr_t ra, rb, input cga_pkg::alu_fn_e fn,
                       input cga_pkg::bsrc_e src, input cga_pkg::cond_e cond,
                       input cga_pkg::comm_e comm, input cga_pkg::word_t cdv, fin,
                       input logic [4:0] bint);
    cga_pkg::word_t bv, res;
    cga_pkg::flags_t fl;
    logic ex;
    exp_t e;
    @(posedge mclk);
    cs_ra <= ra;
    cs_rb <= rb;
    cs_aluf <= fn;
    cs_bsrc <= src;
    cs_cond <= cond;
    cs_comm <= comm;
    cd <= cdv;
    fidb_in <= fin;
    bint_n <= bint;
    case (src)
      cga_pkg::bsrc_reg:  bv = m_regs[rb];
      cga_pkg::bsrc_cd:   bv = cdv;
      cga_pkg::bsrc_fidb: bv = fin;
      default:            bv = '0;
    endcase
    res = ref_alu(fn, m_regs[ra], bv, fl);
    ex = ref_cond(cond, m_flags);
    if (ex && comm == cga_pkg::comm_clpid) m_pid[res[3:0]] = 1'b0;
    m_pid = m_pid | line_pending(bint);  // A low line beats the clear
    if (ex && comm == cga_pkg::comm_setpid) m_pid = m_pid | res;
    if (ex) begin
      m_flags = fl;
      if (comm == cga_pkg::comm_wrf || comm == cga_pkg::comm_wrf_drive) m_regs[ra] = res;
      if (comm == cga_pkg::comm_ldpie) m_pie = res;
      if (comm == cga_pkg::comm_ldpil) m_pil = res[3:0];
      m_oe = (comm == cga_pkg::comm_drive || comm == cga_pkg::comm_wrf_drive);
      if (m_oe) m_fidb = res;
    end
    e.due = cyc + 2;
    e.fidb = m_fidb;
    e.oe = m_oe;
    e.fl = m_flags;
    e.pil = m_pil;
    e.rq_n = ref_priority(m_pid, m_pie, m_pil, e.lvl);
    exp_q.push_back(e);
  endtask

  // A failing condition with quiet lines changes nothing, so it may repeat
  task automatic idle();
    cga_pkg::cond_e c;
    if (m_flags.zf) c = cga_pkg::cond_nzf;
    else c = cga_pkg::cond_zf;
    apply(0, 0, cga_pkg::fn_pass_a, cga_pkg::bsrc_reg, c, cga_pkg::comm_nop, '0, '0, 5'h1f);
  endtask

  task automatic intr_cmd(input cga_pkg::comm_e comm, input cga_pkg::word_t v,
                          input logic [4:0] bint);
    apply(0, 0, cga_pkg::fn_pass_b, cga_pkg::bsrc_cd, cga_pkg::cond_always, comm, v, '0, bint);
  endtask

  task automatic wrf_const(input cga_pkg::reg_addr_t r, input cga_pkg::word_t v);
    apply(r, 0, cga_pkg::fn_pass_b, cga_pkg::bsrc_cd, cga_pkg::cond_always,
          cga_pkg::comm_wrf, v, '0, 5'h1f);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    errs = 0;
  endtask

  task automatic end_test();
    idle();
    while (exp_q.size() != 0) @(negedge mclk);
    n_tests++;
    total_errs += errs;
    if (errs == 0) begin
      $display("Test %s passed", cur_test);
    end else begin
      n_failed++;
      $display("Test %s failed with %0d errors", cur_test, errs);
    end
  endtask

  task automatic test_alu();
    cga_pkg::word_t bnd_a [4] = '{16'h7fff, 16'hffff, 16'h8000, 16'h0000};
    cga_pkg::word_t bnd_b [4] = '{16'h0001, 16'h0001, 16'h0001, 16'h8000};
    cga_pkg::word_t av, bv;
    start_test("alu");
    for (int f = 0; f < 8; f++) begin
      for (int s = 0; s < 3; s++) begin
        for (int k = 0; k < 6; k++) begin
          av = (k < 4) ? bnd_a[k] : rand_bits(16);
          bv = (k < 4) ? bnd_b[k] : rand_bits(16);
          wrf_const(1, av);
          wrf_const(2, bv);
          apply(1, 2, cga_pkg::alu_fn_e'(f), cga_pkg::bsrc_e'(s), cga_pkg::cond_always,
                cga_pkg::comm_drive, (s == 1) ? bv : ~bv, (s == 2) ? bv : ~bv, 5'h1f);
        end
      end
    end
    end_test();
  endtask

  task automatic test_cond();
    cga_pkg::word_t su_x [4] = '{16'h0000, 16'h0005, 16'hffff, 16'hffff};
    cga_pkg::word_t su_y [4] = '{16'h0000, 16'h0000, 16'h0001, 16'h0002};
    start_test("cond");
    for (int st = 0; st < 4; st++) begin
      for (int c = 0; c < 4; c++) begin
        wrf_const(3, su_x[st]);
        apply(3, 0, cga_pkg::fn_add, cga_pkg::bsrc_cd, cga_pkg::cond_always,
              cga_pkg::comm_drive, su_y[st], '0, 5'h1f);  // Sets zf and cry, raises fidb_oe
        apply(4, 0, cga_pkg::fn_pass_b, cga_pkg::bsrc_cd, cga_pkg::cond_e'(c),
              (c % 2) ? cga_pkg::comm_wrf_drive : cga_pkg::comm_wrf, rand_bits(16), '0, 5'h1f);
        apply(4, 4, cga_pkg::fn_pass_a, cga_pkg::bsrc_reg, cga_pkg::cond_always,
              cga_pkg::comm_drive, '0, '0, 5'h1f);
      end
    end
    end_test();
  endtask

  task automatic test_intr();
    logic [1:0] sel;
    cga_pkg::word_t v;
    logic [4:0] lines;
    start_test("intr");
    intr_cmd(cga_pkg::comm_ldpie, 16'hffff, 5'h1f);
    intr_cmd(cga_pkg::comm_nop, '0, 5'b11110);       // Level 10 line pulses
    intr_cmd(cga_pkg::comm_ldpil, 16'd10, 5'h1f);
    intr_cmd(cga_pkg::comm_setpid, 16'h1000, 5'h1f);
    intr_cmd(cga_pkg::comm_clpid, 16'd12, 5'h1f);
    intr_cmd(cga_pkg::comm_clpid, 16'd13, 5'b10111);  // Level 13 held low
    intr_cmd(cga_pkg::comm_clpid, 16'd13, 5'b10111);
    intr_cmd(cga_pkg::comm_clpid, 16'd13, 5'h1f);
    intr_cmd(cga_pkg::comm_nop, '0, 5'b01111);
    intr_cmd(cga_pkg::comm_ldpil, 16'd15, 5'h1f);
    intr_cmd(cga_pkg::comm_ldpie, 16'h0400, 5'h1f);
    intr_cmd(cga_pkg::comm_ldpil, 16'd3, 5'h1f);
    for (int i = 0; i < 30; i++) begin
      sel = rand_bits(2);
      v = rand_bits(16);
      lines = rand_bits(5) | rand_bits(5);
      intr_cmd(cga_pkg::comm_e'(sel + 2), v, lines);  // ldpie, setpid, clpid or ldpil
    end
    end_test();
  endtask

  initial begin
    reset = 1'b1;
    cs_ra = '0;
    cs_rb = '0;
    cs_aluf = cga_pkg::fn_pass_a;
    cs_bsrc = cga_pkg::bsrc_reg;
    cs_cond = cga_pkg::cond_zf;  // False while the flags are clear
    cs_comm = cga_pkg::comm_nop;
    cd = '0;
    fidb_in = '0;
    bint_n = 5'h1f;
    lfsr_state = 16'd4;
    for (int i = 0; i < 16; i++) m_regs[i] = '0;
    {m_fidb, m_pid, m_pie, m_oe, m_flags, m_pil} = '0;
    {errs, checks, total_errs, n_tests, n_failed} = '0;
    repeat (reset_cycles) @(posedge mclk);
    reset <= 1'b0;

    start_test("reset");
    @(negedge mclk);
    check_word('0, fidb_out, 1'b0, fidb_oe);
    check_flags('0, {zf, cry, ovf});
    check_level('0, pil, '0, int_level, 1'b1, intrq_n);
    end_test();

    start_test("wrf");
    for (int r = 0; r < 16; r++) wrf_const(r, rand_bits(16));
    for (int r = 0; r < 16; r++) begin
      apply(r, r, cga_pkg::fn_pass_a, cga_pkg::bsrc_reg, cga_pkg::cond_always,
            cga_pkg::comm_drive, '0, '0, 5'h1f);
    end
    end_test();

    test_alu();
    test_cond();
    test_intr();
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed, checks, total_errs);
    if (total_errs == 0 && n_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: hdl/cga_core.sv
/*
  CGA slice top level
  One microinstruction per mclk cycle. Connects the control
  decoder, ALU, working register file and interrupt block
*/
`timescale 1ns/1ps

module cga_core (
  input  logic                               mclk,
  input  logic                               reset,
  input  cga_pkg::reg_addr_t                 cs_ra,
  input  cga_pkg::reg_addr_t                 cs_rb,
  input  cga_pkg::alu_fn_e                   cs_aluf,
  input  cga_pkg::bsrc_e                     cs_bsrc,
  input  cga_pkg::cond_e                     cs_cond,
  input  cga_pkg::comm_e                     cs_comm,
  input  cga_pkg::word_t                     cd,
  input  cga_pkg::word_t                     fidb_in,
  input  logic [cga_pkg::int_lines_w-1:0]    bint_n,
  output cga_pkg::word_t                     fidb_out,
  output logic                               fidb_oe,
  output logic                               zf,
  output logic                               cry,
  output logic                               ovf,
  output cga_pkg::level_t                    pil,
  output cga_pkg::level_t                    int_level,
  output logic                               intrq_n
);

  cga_pkg::word_t  result;
  cga_pkg::word_t  a;
  cga_pkg::word_t  b_reg;
  cga_pkg::flags_t flags;

  cga_ctl_if ctl ();

  cga_dcd dcd (
    .mclk    (mclk),
    .reset   (reset),
    .cs_cond (cs_cond),
    .cs_comm (cs_comm),
    .flags   (flags),
    .ctl     (ctl.dcd)
  );

  cga_alu alu (
    .mclk     (mclk),
    .reset    (reset),
    .cs_aluf  (cs_aluf),
    .cs_bsrc  (cs_bsrc),
    .cd       (cd),
    .fidb_in  (fidb_in),
    .a        (a),
    .b_reg    (b_reg),
    .ctl      (ctl.alu),
    .result   (result),
    .flags    (flags),
    .fidb_out (fidb_out),
    .fidb_oe  (fidb_oe)
  );

  cga_wrf wrf (
    .mclk  (mclk),
    .reset (reset),
    .cs_ra (cs_ra),
    .cs_rb (cs_rb),
    .wdata (result),
    .ctl   (ctl.wrf),
    .a     (a),
    .b     (b_reg)
  );

  cga_intr intr (
    .mclk      (mclk),
    .reset     (reset),
    .bint_n    (bint_n),
    .wdata     (result),
    .ctl       (ctl.intr),
    .pil       (pil),
    .int_level (int_level),
    .intrq_n   (intrq_n)
  );

  // Flags leave the chip as separate pins
  assign zf  = flags.zf;
  assign cry = flags.cry;
  assign ovf = flags.ovf;

endmodule

// File: intr/cga_intr.sv
/*
  CGA interrupt control
  Pending, enable and program level registers. Lines for
  levels 10 to 13 and 15 are sampled each cycle and the highest
  enabled pending level is compared with the current level
*/
`timescale 1ns/1ps

module cga_intr (
  input  logic                               mclk,
  input  logic                               reset,
  input  logic [cga_pkg::int_lines_w-1:0]    bint_n,
  input  cga_pkg::word_t                     wdata,
  cga_ctl_if.intr                            ctl,
  output cga_pkg::level_t                    pil,
  output cga_pkg::level_t                    int_level,
  output logic                               intrq_n
);

  cga_pkg::word_t pid;       // Pending levels
  cga_pkg::word_t pie;       // Enabled levels
  cga_pkg::word_t line_set;
  cga_pkg::word_t clr_mask;
  cga_pkg::word_t pid_nx;
  cga_pkg::word_t active;

  // Active low lines raise their mapped level
  always_comb begin
    line_set = '0;
    for (int i = 0; i < cga_pkg::int_lines_w; i++) begin
      if (!bint_n[i]) begin
        line_set[cga_pkg::int_line_level[i]] = 1'b1;
      end
    end
  end

  always_comb begin
    clr_mask = '0;
    if (ctl.cl_pid) begin
      clr_mask[wdata[3:0]] = 1'b1;
    end
    // A line that is still low wins over the clear
    pid_nx = (pid & ~clr_mask) | line_set;
    if (ctl.set_pid) begin
      pid_nx = pid_nx | wdata;
    end
  end

  always_ff @(posedge mclk) begin
    if (reset) begin
      pid <= '0;
      pie <= '0;
      pil <= '0;
    end else begin
      pid <= pid_nx;
      if (ctl.ld_pie) begin
        pie <= wdata;
      end
      if (ctl.ld_pil) begin
        pil <= wdata[3:0];
      end
    end
  end

  assign active = pid & pie;

  // Upward scan so the highest set bit wins
  always_comb begin
    int_level = '0;
    for (int i = 0; i < cga_pkg::word_w; i++) begin
      if (active[i]) begin
        int_level = cga_pkg::level_t'(i);
      end
    end
  end

  assign intrq_n = !((active != '0) && (int_level > pil));

  // Level 15 masks every request
  a_pil15_no_req: assert property (
    @(posedge mclk) disable iff (reset)
      (pil == 4'd15) |-> intrq_n
  );

endmodule

// File: wrf/cga_wrf.sv
/*
  CGA working register file
  Sixteen 16-bit registers, two combinational read ports
  and one write port addressed by the A field
*/
`timescale 1ns/1ps

module cga_wrf (
  input  logic                mclk,
  input  logic                reset,
  input  cga_pkg::reg_addr_t  cs_ra,
  input  cga_pkg::reg_addr_t  cs_rb,
  input  cga_pkg::word_t      wdata,
  cga_ctl_if.wrf              ctl,
  output cga_pkg::word_t      a,
  output cga_pkg::word_t      b
);

  cga_pkg::word_t regs [16];

  always_ff @(posedge mclk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (ctl.wrf_we) begin
      regs[cs_ra] <= wdata;
    end
  end

  // Reads see the last write at the next microinstruction
  assign a = regs[cs_ra];
  assign b = regs[cs_rb];

  a_ra_known: assert property (
    @(posedge mclk) disable iff (reset)
      ctl.wrf_we |-> !$isunknown(cs_ra)
  );

endmodule

// File: alu/cga_alu.sv
/*
  CGA ALU
  B operand selection, eight-function ALU, the flag register
  and the registered fidb output with its enable
*/
`timescale 1ns/1ps

module cga_alu (
  input  logic              mclk,
  input  logic              reset,
  input  cga_pkg::alu_fn_e  cs_aluf,
  input  cga_pkg::bsrc_e    cs_bsrc,
  input  cga_pkg::word_t    cd,
  input  cga_pkg::word_t    fidb_in,
  input  cga_pkg::word_t    a,
  input  cga_pkg::word_t    b_reg,
  cga_ctl_if.alu            ctl,
  output cga_pkg::word_t    result,
  output cga_pkg::flags_t   flags,
  output cga_pkg::word_t    fidb_out,
  output logic              fidb_oe
);

  localparam int msb = cga_pkg::word_w - 1;

  cga_pkg::word_t          b;
  cga_pkg::word_t          op2;       // Second adder input
  logic                    cin;
  logic                    arith;     // Add, subtract or increment
  logic [cga_pkg::word_w:0] sum;
  cga_pkg::flags_t         flags_nx;

  always_comb begin
    case (cs_bsrc)
      cga_pkg::bsrc_reg:  b = b_reg;
      cga_pkg::bsrc_cd:   b = cd;
      cga_pkg::bsrc_fidb: b = fidb_in;
      default:            b = '0;     // Reserved source
    endcase
  end

  // One adder serves add, subtract and increment
  always_comb begin
    case (cs_aluf)
      cga_pkg::fn_sub: begin
        op2 = ~b;
        cin = 1'b1;
      end
      cga_pkg::fn_inc_a: begin
        op2 = '0;
        cin = 1'b1;
      end
      default: begin
        op2 = b;
        cin = 1'b0;
      end
    endcase
    sum = {1'b0, a} + {1'b0, op2} + {{cga_pkg::word_w{1'b0}}, cin};
  end

  always_comb begin
    arith = 1'b0;
    case (cs_aluf)
      cga_pkg::fn_add,
      cga_pkg::fn_sub,
      cga_pkg::fn_inc_a: begin
        result = sum[msb:0];
        arith  = 1'b1;
      end
      cga_pkg::fn_and:    result = a & b;
      cga_pkg::fn_or:     result = a | b;
      cga_pkg::fn_xor:    result = a ^ b;
      cga_pkg::fn_pass_a: result = a;
      default:            result = b;   // fn_pass_b
    endcase

    flags_nx.zf  = (result == '0);
    flags_nx.cry = arith && sum[cga_pkg::word_w];
    // Signed overflow when the operands agree in sign and the sum does not
    flags_nx.ovf = arith && (a[msb] == op2[msb]) && (sum[msb] != a[msb]);
  end

  always_ff @(posedge mclk) begin
    if (reset) begin
      flags <= '0;
    end else if (ctl.exec) begin
      flags <= flags_nx;
    end
  end

  always_ff @(posedge mclk) begin
    if (reset) begin
      fidb_out <= '0;
      fidb_oe  <= 1'b0;
    end else if (ctl.drive) begin
      fidb_out <= result;
      fidb_oe  <= 1'b1;
    end else if (ctl.exec) begin
      fidb_oe  <= 1'b0;   // Any other executed command releases the bus
    end
  end

  a_oe_needs_drive: assert property (
    @(posedge mclk) disable iff (reset)
      $rose(fidb_oe) |-> $past(ctl.drive)
  );

endmodule

// File: hdl/cga_dcd.sv
/*
  CGA control decoder
  Evaluates the condition field against the registered flags
  and turns the command field into single-cycle strobes
*/
`timescale 1ns/1ps

module cga_dcd (
  input  logic             mclk,
  input  logic             reset,
  input  cga_pkg::cond_e   cs_cond,
  input  cga_pkg::comm_e   cs_comm,
  input  cga_pkg::flags_t  flags,
  cga_ctl_if.dcd           ctl
);

  logic cond_true;

  always_comb begin
    case (cs_cond)
      cga_pkg::cond_zf:  cond_true = flags.zf;
      cga_pkg::cond_cry: cond_true = flags.cry;
      cga_pkg::cond_nzf: cond_true = !flags.zf;
      default:           cond_true = 1'b1;    // cond_always
    endcase
  end

  always_comb begin
    ctl.exec    = cond_true;
    ctl.wrf_we  = 1'b0;
    ctl.ld_pie  = 1'b0;
    ctl.set_pid = 1'b0;
    ctl.cl_pid  = 1'b0;
    ctl.ld_pil  = 1'b0;
    ctl.drive   = 1'b0;
    if (cond_true) begin
      case (cs_comm)
        cga_pkg::comm_wrf:    ctl.wrf_we  = 1'b1;
        cga_pkg::comm_ldpie:  ctl.ld_pie  = 1'b1;
        cga_pkg::comm_setpid: ctl.set_pid = 1'b1;
        cga_pkg::comm_clpid:  ctl.cl_pid  = 1'b1;
        cga_pkg::comm_ldpil:  ctl.ld_pil  = 1'b1;
        cga_pkg::comm_drive:  ctl.drive   = 1'b1;
        cga_pkg::comm_wrf_drive: begin
          ctl.wrf_we = 1'b1;
          ctl.drive  = 1'b1;
        end
        default: ;                              // comm_nop
      endcase
    end
  end

  // Interrupt register loads are exclusive within a cycle
  a_intr_cmd_onehot: assert property (
    @(posedge mclk) disable iff (reset)
      $onehot0({ctl.ld_pie, ctl.set_pid, ctl.cl_pid, ctl.ld_pil})
  );

endmodule

// File: common/cga_ctl_if.sv
/*
  CGA control strobes
  Decoded command strobes from the control module to the
  ALU, register file and interrupt block
*/
`timescale 1ns/1ps

interface cga_ctl_if;

  logic exec;      // Condition true so flags may update
  logic wrf_we;
  logic ld_pie;
  logic set_pid;
  logic cl_pid;
  logic ld_pil;
  logic drive;     // Result onto fidb

  modport dcd (
    output exec, wrf_we, ld_pie, set_pid, cl_pid, ld_pil, drive
  );

  modport alu (input exec, drive);

  modport wrf (input wrf_we);

  modport intr (input ld_pie, set_pid, cl_pid, ld_pil);

endinterface

// File: common/cga_pkg.sv
/*
  CGA slice shared definitions
  Word and level types, microinstruction field encodings,
  the flag layout and the interrupt line to level table
*/
package cga_pkg;

  localparam int word_w      = 16;
  localparam int int_lines_w = 5;   // External interrupt lines

  typedef logic [word_w-1:0] word_t;
  typedef logic [3:0]        reg_addr_t;   // Working registers 0 to 15
  typedef logic [3:0]        level_t;      // Program and interrupt levels 0 to 15

  typedef enum logic [2:0] {
    fn_add    = 3'd0,
    fn_sub    = 3'd1,
    fn_and    = 3'd2,
    fn_or     = 3'd3,
    fn_xor    = 3'd4,
    fn_pass_a = 3'd5,
    fn_pass_b = 3'd6,
    fn_inc_a  = 3'd7
  } alu_fn_e;

  // Value 3 is reserved and selects zero
  typedef enum logic [1:0] {
    bsrc_reg  = 2'd0,
    bsrc_cd   = 2'd1,
    bsrc_fidb = 2'd2
  } bsrc_e;

  typedef enum logic [1:0] {
    cond_always = 2'd0,
    cond_zf     = 2'd1,
    cond_cry    = 2'd2,
    cond_nzf    = 2'd3
  } cond_e;

  typedef enum logic [2:0] {
    comm_nop       = 3'd0,
    comm_wrf       = 3'd1,
    comm_ldpie     = 3'd2,
    comm_setpid    = 3'd3,
    comm_clpid     = 3'd4,
    comm_ldpil     = 3'd5,
    comm_drive     = 3'd6,
    comm_wrf_drive = 3'd7
  } comm_e;

  typedef struct packed {
    logic zf;
    logic cry;
    logic ovf;
  } flags_t;

  // Line 0 to 4 map to levels 10, 11, 12, 13 and 15
  localparam level_t [int_lines_w-1:0] int_line_level = {
    4'd15, 4'd13, 4'd12, 4'd11, 4'd10
  };

endpackage
